// ==== Bender.yml ====
package:
  name: la32r_core

sources:
  - files:
      - core_pkg.sv
      - fetch_stage.sv
      - decode_stage.sv
      - operand_stage.sv
      - execute_stage.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_core_top.sv

// ==== compile.f ====
+incdir+.
core_pkg.sv
fetch_stage.sv
decode_stage.sv
operand_stage.sv
execute_stage.sv
core_top.sv
tb_core_top.sv

// ==== core_pkg.sv ====
package core_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_idx_t;

    // pc step between sequential instructions
    localparam xlen_t INST_BYTES = 32'd4;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_ADDI,
        OP_LU12I,
        OP_BEQ,
        OP_BNE,
        OP_B,
        OP_BL
    } op_e;

    // ops that produce a register result
    function automatic logic op_writes_rd(input op_e op);
        logic wr;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SLT, OP_SLTU, OP_ADDI, OP_LU12I, OP_BL: begin
                wr = 1'b1;
            end
            default: begin
                wr = 1'b0;
            end
        endcase
        return wr;
    endfunction

endpackage

// ==== core_top.sv ====
`timescale 1ns/1ns

module core_top #(
    parameter core_pkg::xlen_t RESET_PC = 32'h1c000000
) (
    input  logic               aclk,
    input  logic               aresetn,
    output logic               o_wb_cyc,
    output logic               o_wb_stb,
    output core_pkg::xlen_t    o_wb_adr,
    input  logic               i_wb_ack,
    input  core_pkg::xlen_t    i_wb_dat,
    output logic               o_dbg_valid,
    output core_pkg::xlen_t    o_dbg_pc,
    output core_pkg::xlen_t    o_dbg_inst,
    output logic               o_dbg_rf_wen,
    output core_pkg::reg_idx_t o_dbg_rf_wnum,
    output core_pkg::xlen_t    o_dbg_rf_wdata
);
    import core_pkg::*;

    // fetch to decode
    logic     fd_valid;
    logic     fd_ready;
    xlen_t    fd_inst;
    xlen_t    fd_pc;
    // decode to operand
    logic     do_valid;
    logic     do_ready;
    op_e      do_op;
    reg_idx_t do_rd;
    reg_idx_t do_rj;
    reg_idx_t do_rk;
    xlen_t    do_imm;
    xlen_t    do_pc;
    xlen_t    do_inst;
    // operand to execute
    logic     oe_valid;
    op_e      oe_op;
    reg_idx_t oe_rd;
    xlen_t    oe_a;
    xlen_t    oe_b;
    xlen_t    oe_imm;
    xlen_t    oe_pc;
    xlen_t    oe_inst;
    // retirement write port and redirect
    logic     rf_wen;
    reg_idx_t rf_waddr;
    xlen_t    rf_wdata;
    logic     redirect;
    xlen_t    redirect_pc;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .aclk(aclk), .aresetn(aresetn),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
        .i_wb_ack(i_wb_ack), .i_wb_dat(i_wb_dat),
        .o_valid(fd_valid), .i_ready(fd_ready),
        .o_inst(fd_inst), .o_pc(fd_pc),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc)
    );

    decode_stage u_decode (
        .aclk(aclk), .aresetn(aresetn),
        .i_valid(fd_valid), .i_inst(fd_inst), .i_pc(fd_pc),
        .i_ready(do_ready), .i_flush(redirect),
        .o_ready(fd_ready), .o_valid(do_valid), .o_op(do_op),
        .o_rd(do_rd), .o_rj(do_rj), .o_rk(do_rk),
        .o_imm(do_imm), .o_pc(do_pc), .o_inst(do_inst)
    );

    operand_stage u_operand (
        .aclk(aclk), .aresetn(aresetn), .i_flush(redirect),
        .i_valid(do_valid), .i_op(do_op),
        .i_rd(do_rd), .i_rj(do_rj), .i_rk(do_rk),
        .i_imm(do_imm), .i_pc(do_pc), .i_inst(do_inst),
        .i_wen(rf_wen), .i_waddr(rf_waddr), .i_wdata(rf_wdata),
        .o_ready(do_ready), .o_valid(oe_valid), .o_op(oe_op), .o_rd(oe_rd),
        .o_a(oe_a), .o_b(oe_b), .o_imm(oe_imm), .o_pc(oe_pc), .o_inst(oe_inst)
    );

    execute_stage u_execute (
        .aclk(aclk), .aresetn(aresetn),
        .i_valid(oe_valid), .i_op(oe_op), .i_rd(oe_rd),
        .i_a(oe_a), .i_b(oe_b), .i_imm(oe_imm), .i_pc(oe_pc), .i_inst(oe_inst),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_wen(rf_wen), .o_waddr(rf_waddr), .o_wdata(rf_wdata),
        .o_dbg_valid(o_dbg_valid), .o_dbg_pc(o_dbg_pc), .o_dbg_inst(o_dbg_inst),
        .o_dbg_rf_wen(o_dbg_rf_wen), .o_dbg_rf_wnum(o_dbg_rf_wnum),
        .o_dbg_rf_wdata(o_dbg_rf_wdata)
    );

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_valid,
    input  core_pkg::xlen_t    i_inst,
    input  core_pkg::xlen_t    i_pc,
    input  logic               i_ready,
    input  logic               i_flush,
    output logic               o_ready,
    output logic               o_valid,
    output core_pkg::op_e      o_op,
    output core_pkg::reg_idx_t o_rd,
    output core_pkg::reg_idx_t o_rj,
    output core_pkg::reg_idx_t o_rk,
    output core_pkg::xlen_t    o_imm,
    output core_pkg::xlen_t    o_pc,
    output core_pkg::xlen_t    o_inst
);
    import core_pkg::*;

    // la32r major opcode fields
    localparam logic [16:0] F3R_ADD    = 17'h00020;
    localparam logic [16:0] F3R_SUB    = 17'h00022;
    localparam logic [16:0] F3R_SLT    = 17'h00024;
    localparam logic [16:0] F3R_SLTU   = 17'h00025;
    localparam logic [16:0] F3R_AND    = 17'h00029;
    localparam logic [16:0] F3R_OR     = 17'h0002a;
    localparam logic [16:0] F3R_XOR    = 17'h0002b;
    localparam logic [9:0]  F2RI_ADDI  = 10'h00a;
    localparam logic [6:0]  F1RI_LU12I = 7'h0a;
    localparam logic [5:0]  FBR_B      = 6'h14;
    localparam logic [5:0]  FBR_BL     = 6'h15;
    localparam logic [5:0]  FBR_BEQ    = 6'h16;
    localparam logic [5:0]  FBR_BNE    = 6'h17;

    reg_idx_t f_rd;
    reg_idx_t f_rj;
    reg_idx_t f_rk;
    op_e      op3r;
    op_e      dec_op;
    reg_idx_t dec_rd;
    reg_idx_t dec_rj;
    reg_idx_t dec_rk;
    xlen_t    dec_imm;

    assign f_rd = i_inst[4:0];
    assign f_rj = i_inst[9:5];
    assign f_rk = i_inst[14:10];

    always_comb begin
        case (i_inst[31:15])
            F3R_ADD:  op3r = OP_ADD;
            F3R_SUB:  op3r = OP_SUB;
            F3R_SLT:  op3r = OP_SLT;
            F3R_SLTU: op3r = OP_SLTU;
            F3R_AND:  op3r = OP_AND;
            F3R_OR:   op3r = OP_OR;
            F3R_XOR:  op3r = OP_XOR;
            default:  op3r = OP_NOP;
        endcase
    end

    // unused source and dest indices stay at r0 so the hazard check ignores them
    always_comb begin
        dec_op  = OP_NOP;
        dec_rd  = '0;
        dec_rj  = '0;
        dec_rk  = '0;
        dec_imm = '0;
        if (op3r != OP_NOP) begin
            dec_op = op3r;
            dec_rd = f_rd;
            dec_rj = f_rj;
            dec_rk = f_rk;
        end else if (i_inst[31:22] == F2RI_ADDI) begin
            dec_op  = OP_ADDI;
            dec_rd  = f_rd;
            dec_rj  = f_rj;
            dec_imm = {{20{i_inst[21]}}, i_inst[21:10]};
        end else if (i_inst[31:25] == F1RI_LU12I) begin
            dec_op  = OP_LU12I;
            dec_rd  = f_rd;
            dec_imm = {i_inst[24:5], 12'b0};
        end else begin
            case (i_inst[31:26])
                FBR_BEQ, FBR_BNE: begin
                    dec_op  = (i_inst[26]) ? OP_BNE : OP_BEQ;
                    // second compare operand sits in the rd field
                    dec_rj  = f_rj;
                    dec_rk  = f_rd;
                    dec_imm = {{14{i_inst[25]}}, i_inst[25:10], 2'b00};
                end
                FBR_B, FBR_BL: begin
                    dec_op  = (i_inst[26]) ? OP_BL : OP_B;
                    dec_rd  = (i_inst[26]) ? 5'd1 : 5'd0;
                    dec_imm = {{4{i_inst[9]}}, i_inst[9:0], i_inst[25:10], 2'b00};
                end
                default: begin
                    dec_op = OP_NOP;
                end
            endcase
        end
    end

    assign o_ready = !o_valid || i_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (o_ready && i_valid) begin
            o_op   <= dec_op;
            o_rd   <= dec_rd;
            o_rj   <= dec_rj;
            o_rk   <= dec_rk;
            o_imm  <= dec_imm;
            o_pc   <= i_pc;
            o_inst <= i_inst;
        end
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_valid,
    input  core_pkg::op_e      i_op,
    input  core_pkg::reg_idx_t i_rd,
    input  core_pkg::xlen_t    i_a,
    input  core_pkg::xlen_t    i_b,
    input  core_pkg::xlen_t    i_imm,
    input  core_pkg::xlen_t    i_pc,
    input  core_pkg::xlen_t    i_inst,
    output logic               o_redirect,
    output core_pkg::xlen_t    o_redirect_pc,
    output logic               o_wen,
    output core_pkg::reg_idx_t o_waddr,
    output core_pkg::xlen_t    o_wdata,
    output logic               o_dbg_valid,
    output core_pkg::xlen_t    o_dbg_pc,
    output core_pkg::xlen_t    o_dbg_inst,
    output logic               o_dbg_rf_wen,
    output core_pkg::reg_idx_t o_dbg_rf_wnum,
    output core_pkg::xlen_t    o_dbg_rf_wdata
);
    import core_pkg::*;

    xlen_t    result;
    logic     taken;
    logic     ret_valid;
    logic     ret_wen;
    reg_idx_t ret_rd;
    xlen_t    ret_data;
    xlen_t    ret_pc;
    xlen_t    ret_inst;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (i_op)
            OP_ADD:   result = i_a + i_b;
            OP_SUB:   result = i_a - i_b;
            OP_AND:   result = i_a & i_b;
            OP_OR:    result = i_a | i_b;
            OP_XOR:   result = i_a ^ i_b;
            OP_SLT:   result = {31'b0, $signed(i_a) < $signed(i_b)};
            OP_SLTU:  result = {31'b0, i_a < i_b};
            OP_ADDI:  result = i_a + i_imm;
            OP_LU12I: result = i_imm;
            OP_BEQ:   taken  = (i_a == i_b);
            OP_BNE:   taken  = (i_a != i_b);
            OP_B:     taken  = 1'b1;
            OP_BL: begin
                taken  = 1'b1;
                // link address into r1
                result = i_pc + INST_BYTES;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign o_redirect    = i_valid && taken;
    assign o_redirect_pc = i_pc + i_imm;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ret_valid <= 1'b0;
            ret_wen   <= 1'b0;
        end else begin
            ret_valid <= i_valid;
            ret_wen   <= i_valid && op_writes_rd(i_op) && (i_rd != '0);
        end
    end

    always_ff @(posedge aclk) begin
        ret_rd   <= i_rd;
        ret_data <= result;
        ret_pc   <= i_pc;
        ret_inst <= i_inst;
    end

    assign o_wen          = ret_wen;
    assign o_waddr        = ret_rd;
    assign o_wdata        = ret_data;
    assign o_dbg_valid    = ret_valid;
    assign o_dbg_pc       = ret_pc;
    assign o_dbg_inst     = ret_inst;
    assign o_dbg_rf_wen   = ret_wen;
    assign o_dbg_rf_wnum  = ret_rd;
    assign o_dbg_rf_wdata = ret_data;

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage #(
    parameter core_pkg::xlen_t RESET_PC = 32'h1c000000
) (
    input  logic            aclk,
    input  logic            aresetn,
    output logic            o_wb_cyc,
    output logic            o_wb_stb,
    output core_pkg::xlen_t o_wb_adr,
    input  logic            i_wb_ack,
    input  core_pkg::xlen_t i_wb_dat,
    output logic            o_valid,
    input  logic            i_ready,
    output core_pkg::xlen_t o_inst,
    output core_pkg::xlen_t o_pc,
    input  logic            i_redirect,
    input  core_pkg::xlen_t i_redirect_pc
);
    import core_pkg::*;

    typedef enum logic [0:0] {
        FS_IDLE,
        FS_BUS
    } fetch_state_e;

    fetch_state_e state;
    xlen_t        pc;
    xlen_t        bus_adr;
    logic         drop;
    logic         buf_valid;
    xlen_t        buf_inst;
    xlen_t        buf_pc;
    logic         start;
    logic         keep;
    logic         drain;

    // a new cycle only when the buffer is free by the time data can land
    assign start = (state == FS_IDLE) && (!buf_valid || i_ready) && !i_redirect;
    // word from a redirected cycle is thrown away
    assign keep  = (state == FS_BUS) && i_wb_ack && !drop && !i_redirect;
    assign drain = buf_valid && i_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= FS_IDLE;
        end else begin
            case (state)
                FS_IDLE: begin
                    if (start) begin
                        state <= FS_BUS;
                    end
                end
                FS_BUS: begin
                    if (i_wb_ack) begin
                        state <= FS_IDLE;
                    end
                end
                default: begin
                    state <= FS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            drop <= 1'b0;
        end else if (state == FS_BUS && i_wb_ack) begin
            drop <= 1'b0;
        end else if (state == FS_BUS && i_redirect) begin
            drop <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc <= RESET_PC;
        end else if (i_redirect) begin
            pc <= i_redirect_pc;
        end else if (keep) begin
            pc <= pc + INST_BYTES;
        end
    end

    // address held stable for the whole cycle
    always_ff @(posedge aclk) begin
        if (start) begin
            bus_adr <= pc;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            buf_valid <= 1'b0;
        end else if (i_redirect) begin
            buf_valid <= 1'b0;
        end else if (keep) begin
            buf_valid <= 1'b1;
        end else if (drain) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (keep) begin
            buf_inst <= i_wb_dat;
            buf_pc   <= bus_adr;
        end
    end

    assign o_wb_cyc = (state == FS_BUS);
    assign o_wb_stb = (state == FS_BUS);
    assign o_wb_adr = bus_adr;
    assign o_valid  = buf_valid;
    assign o_inst   = buf_inst;
    assign o_pc     = buf_pc;

endmodule

// ==== operand_stage.sv ====
`timescale 1ns/1ns

module operand_stage (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_flush,
    input  logic               i_valid,
    input  core_pkg::op_e      i_op,
    input  core_pkg::reg_idx_t i_rd,
    input  core_pkg::reg_idx_t i_rj,
    input  core_pkg::reg_idx_t i_rk,
    input  core_pkg::xlen_t    i_imm,
    input  core_pkg::xlen_t    i_pc,
    input  core_pkg::xlen_t    i_inst,
    input  logic               i_wen,
    input  core_pkg::reg_idx_t i_waddr,
    input  core_pkg::xlen_t    i_wdata,
    output logic               o_ready,
    output logic               o_valid,
    output core_pkg::op_e      o_op,
    output core_pkg::reg_idx_t o_rd,
    output core_pkg::xlen_t    o_a,
    output core_pkg::xlen_t    o_b,
    output core_pkg::xlen_t    o_imm,
    output core_pkg::xlen_t    o_pc,
    output core_pkg::xlen_t    o_inst
);
    import core_pkg::*;

    xlen_t regs [NUM_REGS];
    xlen_t rdata_j;
    xlen_t rdata_k;
    logic  hazard;

    // r0 reads zero, a write in flight is forwarded
    function automatic xlen_t rf_read(
        input reg_idx_t idx,
        input xlen_t    stored,
        input logic     wen,
        input reg_idx_t waddr,
        input xlen_t    wdata
    );
        xlen_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wen && waddr == idx) begin
            val = wdata;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge aclk) begin
        if (i_wen) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    assign rdata_j = rf_read(i_rj, regs[i_rj], i_wen, i_waddr, i_wdata);
    assign rdata_k = rf_read(i_rk, regs[i_rk], i_wen, i_waddr, i_wdata);

    // result of the instruction now in execute is not in the file yet
    assign hazard  = o_valid && (o_rd != '0) && (o_rd == i_rj || o_rd == i_rk);
    assign o_ready = !hazard;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid && !hazard && !i_flush;
        end
    end

    always_ff @(posedge aclk) begin
        o_op   <= i_op;
        o_rd   <= i_rd;
        o_a    <= rdata_j;
        o_b    <= rdata_k;
        o_imm  <= i_imm;
        o_pc   <= i_pc;
        o_inst <= i_inst;
    end

endmodule

// ==== tb_isa_model.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int PROG_LEN = 200;

// instruction kinds of the generated program
localparam int K_ADD   = 0;
localparam int K_SUB   = 1;
localparam int K_AND   = 2;
localparam int K_OR    = 3;
localparam int K_XOR   = 4;
localparam int K_SLT   = 5;
localparam int K_SLTU  = 6;
localparam int K_ADDI  = 7;
localparam int K_LU12I = 8;
localparam int K_BEQ   = 9;
localparam int K_BNE   = 10;
localparam int K_B     = 11;
localparam int K_BL    = 12;

int          prog_kind [PROG_LEN];
logic [4:0]  prog_rd   [PROG_LEN];
logic [4:0]  prog_rj   [PROG_LEN];
logic [4:0]  prog_rk   [PROG_LEN];
logic [31:0] prog_imm  [PROG_LEN];
logic [31:0] prog_word [PROG_LEN];

// expected retirement trace, oldest first
logic [31:0] exp_pc    [$];
logic [31:0] exp_inst  [$];
logic        exp_wen   [$];
logic [4:0]  exp_wnum  [$];
logic [31:0] exp_wdata [$];

// la32r base encodings, branch offsets in words
function automatic logic [31:0] encode_inst(
    input int          kind,
    input logic [4:0]  rd,
    input logic [4:0]  rj,
    input logic [4:0]  rk,
    input logic [31:0] imm
);
    logic [31:0] w;
    case (kind)
        K_ADD:   w = {17'h00020, rk, rj, rd};
        K_SUB:   w = {17'h00022, rk, rj, rd};
        K_AND:   w = {17'h00029, rk, rj, rd};
        K_OR:    w = {17'h0002a, rk, rj, rd};
        K_XOR:   w = {17'h0002b, rk, rj, rd};
        K_SLT:   w = {17'h00024, rk, rj, rd};
        K_SLTU:  w = {17'h00025, rk, rj, rd};
        K_ADDI:  w = {10'h00a, imm[11:0], rj, rd};
        K_LU12I: w = {7'h0a, imm[19:0], rd};
        // second compare register sits in the rd field
        K_BEQ:   w = {6'h16, imm[15:0], rj, rk};
        K_BNE:   w = {6'h17, imm[15:0], rj, rk};
        K_B:     w = {6'h14, imm[15:0], imm[25:16]};
        default: w = {6'h15, imm[15:0], imm[25:16]};
    endcase
    return w;
endfunction

// half the time reuse the last destination
function automatic logic [4:0] pick_source(input logic [4:0] last);
    logic [4:0] r;
    if ($urandom % 2 == 0) begin
        r = last;
    end else begin
        r = 5'($urandom % 8);
    end
    return r;
endfunction

task automatic gen_program();
    int          i;
    int          v;
    int          span;
    logic [4:0]  last;
    last = 5'd1;
    for (i = 0; i < PROG_LEN; i++) begin
        prog_rd[i]  = '0;
        prog_rj[i]  = '0;
        prog_rk[i]  = '0;
        prog_imm[i] = '0;
        if (i < 7) begin
            // give r1..r7 known values first
            prog_kind[i] = K_ADDI;
            prog_rd[i]   = 5'(i + 1);
            prog_imm[i]  = $urandom % 4096;
        end else if (i == PROG_LEN - 1) begin
            prog_kind[i] = K_B;
        end else begin
            v = $urandom % 16;
            if (v < 7) begin
                prog_kind[i] = v;
            end else if (v < 10) begin
                prog_kind[i] = K_ADDI;
            end else if (v == 10) begin
                prog_kind[i] = K_LU12I;
            end else if (v == 11 || v == 15) begin
                prog_kind[i] = K_BEQ;
            end else if (v == 12) begin
                prog_kind[i] = K_BNE;
            end else if (v == 13) begin
                prog_kind[i] = K_B;
            end else begin
                prog_kind[i] = K_BL;
            end
            if (prog_kind[i] >= K_BEQ) begin
                span = 1 + $urandom % 4;
                if (span > PROG_LEN - 1 - i) begin
                    span = PROG_LEN - 1 - i;
                end
                prog_imm[i] = span;
                prog_rj[i]  = pick_source(last);
                prog_rk[i]  = ($urandom % 2 == 0) ? prog_rj[i] : pick_source(last);
                if (prog_kind[i] == K_BL) begin
                    prog_rd[i] = 5'd1;
                    last       = 5'd1;
                end
            end else begin
                prog_rd[i] = 5'($urandom % 8);
                prog_rj[i] = pick_source(last);
                prog_rk[i] = pick_source(last);
                if (prog_kind[i] == K_LU12I) begin
                    prog_imm[i] = $urandom % (1 << 20);
                end else if (prog_kind[i] == K_ADDI) begin
                    prog_imm[i] = $urandom % 4096;
                end
                if (prog_rd[i] != 0) begin
                    last = prog_rd[i];
                end
            end
        end
        prog_word[i] = encode_inst(prog_kind[i], prog_rd[i], prog_rj[i],
                                   prog_rk[i], prog_imm[i]);
    end
endtask

// interprets from RESET_PC until the final self-loop has run twice
task automatic run_model();
    logic [31:0] regs [32];
    int          idx;
    int          loops;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        wr;
    logic        taken;
    for (idx = 0; idx < 32; idx++) begin
        regs[idx] = '0;
    end
    idx   = 0;
    loops = 0;
    while (loops < 2) begin
        pc    = RESET_PC + 32'(idx * 4);
        a     = regs[prog_rj[idx]];
        b     = regs[prog_rk[idx]];
        res   = '0;
        wr    = 1'b1;
        taken = 1'b0;
        case (prog_kind[idx])
            K_ADD:   res = a + b;
            K_SUB:   res = a - b;
            K_AND:   res = a & b;
            K_OR:    res = a | b;
            K_XOR:   res = a ^ b;
            K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            K_ADDI:  res = a + {{20{prog_imm[idx][11]}}, prog_imm[idx][11:0]};
            K_LU12I: res = {prog_imm[idx][19:0], 12'b0};
            K_BEQ: begin
                wr    = 1'b0;
                taken = (a == b);
            end
            K_BNE: begin
                wr    = 1'b0;
                taken = (a != b);
            end
            K_B: begin
                wr    = 1'b0;
                taken = 1'b1;
            end
            default: begin
                res   = pc + 32'd4;
                taken = 1'b1;
            end
        endcase
        wr = wr && (prog_rd[idx] != 0);
        exp_pc.push_back(pc);
        exp_inst.push_back(prog_word[idx]);
        exp_wen.push_back(wr);
        exp_wnum.push_back(prog_rd[idx]);
        exp_wdata.push_back(res);
        if (wr) begin
            regs[prog_rd[idx]] = res;
        end
        if (idx == PROG_LEN - 1) begin
            loops++;
        end
        idx = taken ? idx + int'(prog_imm[idx]) : idx + 1;
    end
endtask

`endif

// ==== tb_core_top.sv ====
`timescale 1ns/1ns

module tb_core_top;

    localparam logic [31:0] RESET_PC   = 32'h1c000000;
    localparam int          CLK_PERIOD = 40;
    localparam int          SEED       = 32'h89a3;
    localparam int          WAIT_SLOTS = 1024;

    `include "tb_isa_model.svh"

    // reset plus 12 cycles per program instruction
    localparam int TIMEOUT_NS = (3 + PROG_LEN * 12) * CLK_PERIOD;

    logic        aclk;
    logic        aresetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic        wb_ack;
    logic [31:0] wb_dat;
    logic        dbg_valid;
    logic [31:0] dbg_pc;
    logic [31:0] dbg_inst;
    logic        dbg_rf_wen;
    logic [4:0]  dbg_rf_wnum;
    logic [31:0] dbg_rf_wdata;

    int          errors;
    int          n_checked;
    int          exp_count;
    int          seed_val;
    int          wait_tab [WAIT_SLOTS];
    int          wait_ptr;
    int          wait_left;
    logic        bus_busy;
    logic        seen_first;
    logic [31:0] cyc_adr;

    core_top #(
        .RESET_PC(RESET_PC)
    ) u_core_top (
        .aclk(aclk), .aresetn(aresetn),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr),
        .i_wb_ack(wb_ack), .i_wb_dat(wb_dat),
        .o_dbg_valid(dbg_valid), .o_dbg_pc(dbg_pc), .o_dbg_inst(dbg_inst),
        .o_dbg_rf_wen(dbg_rf_wen), .o_dbg_rf_wnum(dbg_rf_wnum),
        .o_dbg_rf_wdata(dbg_rf_wdata)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // outside the program the word is derived from its address
    function automatic logic [31:0] mem_read(input logic [31:0] adr);
        logic [31:0] off;
        logic [31:0] word;
        off = adr - RESET_PC;
        if (adr >= RESET_PC && off < PROG_LEN * 4 && off[1:0] == 2'b00) begin
            word = prog_word[off >> 2];
        end else begin
            word = ~adr ^ 32'h5a5a0000;
        end
        return word;
    endfunction

    initial begin
        aclk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) aclk = ~aclk;
        end
    end

    // wishbone classic slave with 0 to 3 wait cycles
    always @(posedge aclk) begin
        #2;
        if (!aresetn) begin
            wb_ack   = 1'b0;
            bus_busy = 1'b0;
        end else if (wb_ack) begin
            wb_ack   = 1'b0;
            bus_busy = 1'b0;
            check_value("wb_cyc after ack", wb_cyc, 1'b0);
            check_value("wb_stb after ack", wb_stb, 1'b0);
        end else if (wb_cyc && wb_stb) begin
            if (!seen_first) begin
                check_value("first wb_adr", wb_adr, RESET_PC);
                seen_first = 1'b1;
            end
            if (!bus_busy) begin
                bus_busy  = 1'b1;
                cyc_adr   = wb_adr;
                wait_left = wait_tab[wait_ptr % WAIT_SLOTS];
                wait_ptr++;
            end
            check_value("wb_adr stable", wb_adr, cyc_adr);
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                wb_dat = mem_read(wb_adr);
            end else begin
                wait_left--;
            end
        end else begin
            // stb and cyc move together
            check_value("wb_stb with wb_cyc", wb_stb, wb_cyc);
        end
    end

    // retirement checker
    always @(negedge aclk) begin
        if (aresetn && dbg_valid && n_checked < exp_count) begin
            check_value("dbg_pc", dbg_pc, exp_pc[n_checked]);
            check_value("dbg_inst", dbg_inst, exp_inst[n_checked]);
            check_value("dbg_rf_wen", dbg_rf_wen, exp_wen[n_checked]);
            if (exp_wen[n_checked]) begin
                check_value("dbg_rf_wnum", dbg_rf_wnum, exp_wnum[n_checked]);
                check_value("dbg_rf_wdata", dbg_rf_wdata, exp_wdata[n_checked]);
            end
            n_checked++;
        end
    end

    initial begin
        int i;
        aresetn    = 1'b0;
        wb_ack     = 1'b0;
        wb_dat     = '0;
        errors     = 0;
        n_checked  = 0;
        exp_count  = 0;
        wait_ptr   = 0;
        wait_left  = 0;
        bus_busy   = 1'b0;
        seen_first = 1'b0;
        cyc_adr    = '0;
        seed_val   = $urandom(SEED);
        for (i = 0; i < WAIT_SLOTS; i++) begin
            wait_tab[i] = $urandom % 4;
        end
        gen_program();
        run_model();
        exp_count = exp_pc.size();
        repeat (3) @(posedge aclk);
        #2;
        check_value("wb_cyc in reset", wb_cyc, 1'b0);
        check_value("wb_stb in reset", wb_stb, 1'b0);
        check_value("dbg_valid in reset", dbg_valid, 1'b0);
        aresetn = 1'b1;
        wait (n_checked >= exp_count);
        $display("retired %0d of %0d expected instructions, %0d errors",
                 n_checked, exp_count, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout after %0d ns, only %0d of %0d instructions retired, %0d errors",
                 TIMEOUT_NS, n_checked, exp_count, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
